//--- tb.f
+incdir+testbench
source/fpAddPkg.sv
source/fpOperandIf.sv
source/fpAlignIf.sv
source/fpClassify.sv
source/fpAlign.sv
source/fpAddNorm.sv
source/fpCombAdder.sv
source/fpAddUnit.sv
testbench/tbFpAdd.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tbFpAdd
FILELIST  = tb.f
LOG       = sim.log
PASSMSG   = all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "$(PASSMSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/fpRefModel.svh
// Reference binary32 addition in exact wide-integer arithmetic with single rounding
`ifndef fpRefModelSvh
`define fpRefModelSvh

// Operands scaled by 2^149 so every normal value is an exact integer
function automatic fpAddPkg::fpWord fpAddRef(input fpAddPkg::fpWord a,
                                             input fpAddPkg::fpWord b);
  logic [279:0] magA;
  logic [279:0] magB;
  logic [279:0] mag;
  logic [279:0] rem;
  logic [279:0] half;
  logic [24:0]  keep;
  logic         sign;
  logic         nanA;
  logic         nanB;
  logic         infA;
  logic         infB;
  int           expA;
  int           expB;
  int           msb;
  int           shift;
  int           biased;
  int           i;
  expA = int'(a[30:23]);
  expB = int'(b[30:23]);
  nanA = (expA == 255) && (a[22:0] != 23'h0);
  nanB = (expB == 255) && (b[22:0] != 23'h0);
  infA = (expA == 255) && (a[22:0] == 23'h0);
  infB = (expB == 255) && (b[22:0] == 23'h0);
  if (nanA || nanB || (infA && infB && (a[31] != b[31]))) return 32'h7FC00000;
  if (infA) return {a[31], 8'hFF, 23'h0};
  if (infB) return {b[31], 8'hFF, 23'h0};
  if (expA == 0 && expB == 0) return {a[31] & b[31], 31'h0};  // Subnormals count as zero
  if (expA == 0) return b;
  if (expB == 0) return a;
  magA = 280'({1'b1, a[22:0]}) << (expA - 1);
  magB = 280'({1'b1, b[22:0]}) << (expB - 1);
  if (a[31] == b[31]) begin
    mag  = magA + magB;
    sign = a[31];
  end else if (magA > magB) begin
    mag  = magA - magB;
    sign = a[31];
  end else if (magB > magA) begin
    mag  = magB - magA;
    sign = b[31];
  end else begin
    return 32'h0;  // Exact cancellation
  end
  msb = 0;
  for (i = 0; i < 280; i++) begin
    if (mag[i]) msb = i;
  end
  if (msb < 23) return {sign, 31'h0};  // Below the normal range
  shift  = msb - 23;
  biased = msb - 22;
  keep   = 25'(mag >> shift);
  if (shift > 0) begin
    rem  = mag & ((280'(1) << shift) - 280'(1));
    half = 280'(1) << (shift - 1);
    if (rem > half || (rem == half && keep[0])) keep = keep + 25'd1;
  end
  if (keep[24]) begin
    keep   = keep >> 1;
    biased = biased + 1;
  end
  if (biased >= 255) return {sign, 8'hFF, 23'h0};
  return {sign, 8'(biased), keep[22:0]};
endfunction

`endif

//--- testbench/tbFpAdd.sv
// Testbench for fpAddUnit with handshake driver, directed tests and random sweep
`timescale 1ns/1ps

module tbFpAdd;

  localparam int ackTimeout = 20;   // Cycles allowed per ack edge
  localparam int sweepCount = 200;

  logic            clk;
  logic            rst;
  logic            req;
  fpAddPkg::fpWord opA;
  fpAddPkg::fpWord opB;
  logic            ack;
  fpAddPkg::fpWord sum;

  int     errors;
  int     checks;
  logic   timedOut;
  integer seed;

  `include "fpRefModel.svh"

  fpAddUnit uut (
    .clk(clk),
    .rst(rst),
    .req(req),
    .opA(opA),
    .opB(opB),
    .ack(ack),
    .sum(sum)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==========================================================================
  // Checks and handshake driver
  // ==========================================================================
  task automatic checkValue(input string name, input fpAddPkg::fpWord got,
                            input fpAddPkg::fpWord expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic expected);
    checks++;
    assert (got === expected) else begin
      errors++;
      $display("mismatch at %0t ns: %s = %b, expected %b", $time, name, got, expected);
    end
  endtask

  task automatic checkCount(input string name, input int got, input int expected);
    checks++;
    assert (got == expected) else begin
      errors++;
      $display("mismatch at %0t ns: %s = %0d, expected %0d", $time, name, got, expected);
    end
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they settle
  task automatic runRequest(input fpAddPkg::fpWord a, input fpAddPkg::fpWord b,
                            input int holdCycles, output fpAddPkg::fpWord result,
                            output int riseCycles, output int fallCycles);
    int waited;
    int i;
    result     = '0;
    riseCycles = -1;
    fallCycles = -1;
    if (timedOut) return;
    @(posedge clk);
    req <= 1'b1;
    opA <= a;
    opB <= b;
    @(posedge clk);  // Capture edge
    @(negedge clk);
    waited = 0;
    while (ack !== 1'b1 && waited < ackTimeout) begin
      @(negedge clk);
      waited++;
    end
    if (ack !== 1'b1) begin
      errors++;
      timedOut = 1'b1;
      $display("timeout at %0t ns: ack never rose after a request", $time);
      return;
    end
    riseCycles = waited;
    result     = sum;
    for (i = 0; i < holdCycles; i++) begin  // Back-pressure
      @(negedge clk);
      checkValue("sum", sum, result);
      checkBit("ack", ack, 1'b1);
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    waited = 0;
    while (ack !== 1'b0 && waited < ackTimeout) begin
      @(negedge clk);
      waited++;
    end
    if (ack !== 1'b0) begin
      errors++;
      timedOut = 1'b1;
      $display("timeout at %0t ns: ack stayed high after req was dropped", $time);
      return;
    end
    fallCycles = waited;
  endtask

  task automatic addCheck(input fpAddPkg::fpWord a, input fpAddPkg::fpWord b,
                          output fpAddPkg::fpWord got);
    int rise;
    int fall;
    runRequest(a, b, 0, got, rise, fall);
    if (timedOut) return;
    checkValue($sformatf("sum(%h + %h)", a, b), got, fpAddRef(a, b));
  endtask

  task automatic addExpect(input fpAddPkg::fpWord a, input fpAddPkg::fpWord b,
                           input fpAddPkg::fpWord known);
    fpAddPkg::fpWord got;
    addCheck(a, b, got);
    if (timedOut) return;
    checkValue($sformatf("sum(%h + %h)", a, b), got, known);
  endtask

  // ==========================================================================
  // Tests
  // ==========================================================================
  task automatic testHandshake();
    fpAddPkg::fpWord got;
    int              rise;
    int              fall;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkBit("ack", ack, 1'b0);  // Low right after reset
    runRequest(32'h3FC00000, 32'h40100000, 6, got, rise, fall);
    if (timedOut) return;
    checkCount("ack rise cycles", rise, 2);
    checkCount("ack fall cycles", fall, 1);
    checkValue("sum", got, fpAddRef(32'h3FC00000, 32'h40100000));
  endtask

  task automatic testExactSums();
    addExpect(32'h3FC00000, 32'h40100000, 32'h40700000);  // 1.5 + 2.25
    addExpect(32'h40400000, 32'hBF800000, 32'h40000000);  // 3 - 1
    addExpect(32'h41200000, 32'hBF000000, 32'h41180000);
    addExpect(32'h3F800000, 32'hBF400000, 32'h3E800000);
    addExpect(32'hC0400000, 32'hBF800000, 32'hC0800000);
    addExpect(32'h3FC00000, 32'hBFC00000, 32'h00000000);  // x + -x
    addExpect(32'hC0200000, 32'h40200000, 32'h00000000);
  endtask

  task automatic testRounding();
    addExpect(32'h3F800000, 32'h33800000, 32'h3F800000);  // Tie stays even
    addExpect(32'h3F800001, 32'h33800000, 32'h3F800002);  // Tie rounds up to even
    addExpect(32'h3F800001, 32'h3F800000, 32'h40000000);  // Tie after carry
    addExpect(32'h3F800003, 32'h3F800000, 32'h40000002);
    addExpect(32'h4B800000, 32'h3F800000, 32'h4B800000);
    addExpect(32'h4B800001, 32'h3F800000, 32'h4B800002);
    addExpect(32'h3F800000, 32'hB3400000, 32'h3F7FFFFF);  // Neighbour below
    addExpect(32'h3F800000, 32'h30800000, 32'h3F800000);  // Sticky only
    addExpect(32'h3F800000, 32'hB0800000, 32'h3F800000);
  endtask

  task automatic testSpecials();
    addExpect(32'h7F800001, 32'h3F800000, 32'h7FC00000);
    addExpect(32'h3F800000, 32'hFFC12345, 32'h7FC00000);
    addExpect(32'h7F800000, 32'hFF800000, 32'h7FC00000);
    addExpect(32'h7F800000, 32'hC1200000, 32'h7F800000);
    addExpect(32'h3F800000, 32'hFF800000, 32'hFF800000);
    addExpect(32'h00000001, 32'h3F800000, 32'h3F800000);  // Subnormal flushed
    addExpect(32'h807FFFFF, 32'hC0400000, 32'hC0400000);
    addExpect(32'h80000000, 32'h80000000, 32'h80000000);
    addExpect(32'h00000000, 32'h80000000, 32'h00000000);
    addExpect(32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000);  // Overflow
    addExpect(32'hFF7FFFFF, 32'hFF000000, 32'hFF800000);
    addExpect(32'h00800001, 32'h80800000, 32'h00000000);  // Underflow flush
    addExpect(32'h80800001, 32'h00800000, 32'h80000000);
  endtask

  task automatic testRandomSweep();
    fpAddPkg::fpWord a;
    fpAddPkg::fpWord b;
    fpAddPkg::fpWord got;
    int              i;
    for (i = 0; i < sweepCount; i++) begin
      a = $random(seed);
      b = $random(seed);
      if (i % 4 == 0) b = {~a[31], a[30:0] ^ (31'($random(seed)) & 31'h3FF)};
      if (i % 4 == 1) b[30:23] = a[30:23] - 8'($random(seed) & 7);  // Close exponents
      if (a[30:23] == 8'hFF) a[30] = 1'b0;  // Finite only
      if (b[30:23] == 8'hFF) b[30] = 1'b0;
      addCheck(a, b, got);
    end
  endtask

  // ==========================================================================
  // Sequence
  // ==========================================================================
  initial begin
    errors   = 0;
    checks   = 0;
    timedOut = 1'b0;
    seed     = 32'h6963;
    rst      = 1'b1;
    req      = 1'b0;
    opA      = '0;
    opB      = '0;
    testHandshake();
    testExactSums();
    testRounding();
    testSpecials();
    testRandomSweep();
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- source/fpAddUnit.sv
// Registered binary32 adder behind a four-phase req/ack handshake
`timescale 1ns/1ps

module fpAddUnit (
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  fpAddPkg::fpWord opA,
  input  fpAddPkg::fpWord opB,
  output logic            ack,
  output fpAddPkg::fpWord sum
);

  fpAddPkg::unitState state;
  fpAddPkg::fpWord    opARegd;  // Latched operands
  fpAddPkg::fpWord    opBRegd;
  fpAddPkg::fpWord    adderOut;

  fpCombAdder adder (
    .a  (opARegd),
    .b  (opBRegd),
    .sum(adderOut)
  );

  // ==========================================================================
  // Payload registers
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (state == fpAddPkg::stateIdle && req) begin
      opARegd <= opA;
      opBRegd <= opB;
    end
    if (state == fpAddPkg::stateCompute) begin
      sum <= adderOut;  // Stable from here until the next request
    end
  end

  // ==========================================================================
  // Handshake FSM
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fpAddPkg::stateIdle;
      ack   <= 1'b0;
    end else begin
      case (state)
        fpAddPkg::stateIdle: begin
          if (req) state <= fpAddPkg::stateCompute;
        end
        fpAddPkg::stateCompute: begin
          state <= fpAddPkg::stateHold;
        end
        fpAddPkg::stateHold: begin
          if (!ack) begin
            ack <= 1'b1;  // Second edge after capture
          end else if (!req) begin
            // Requester let go
            ack   <= 1'b0;
            state <= fpAddPkg::stateRelease;
          end
        end
        fpAddPkg::stateRelease: begin
          state <= fpAddPkg::stateIdle;
        end
        default: state <= fpAddPkg::stateIdle;
      endcase
    end
  end

endmodule

//--- source/fpCombAdder.sv
// Combinational binary32 adder with special-value result selection
`timescale 1ns/1ps

module fpCombAdder (
  input  fpAddPkg::fpWord a,
  input  fpAddPkg::fpWord b,
  output fpAddPkg::fpWord sum
);

  fpAddPkg::fpWord normResult;
  fpAddPkg::fpWord infA;
  fpAddPkg::fpWord infB;
  fpAddPkg::fpWord flushA;
  fpAddPkg::fpWord flushB;
  logic            invalid;

  fpOperandIf opIfA ();
  fpOperandIf opIfB ();
  fpAlignIf   alignBus ();

  // ==========================================================================
  // Datapath
  // ==========================================================================
  fpClassify classA (
    .operand(a),
    .op     (opIfA)
  );

  fpClassify classB (
    .operand(b),
    .op     (opIfB)
  );

  fpAlign align (
    .a      (opIfA),
    .b      (opIfB),
    .aligned(alignBus)
  );

  fpAddNorm norm (
    .aligned(alignBus),
    .result (normResult)
  );

  // ==========================================================================
  // Special results
  // ==========================================================================
  assign invalid = opIfA.isNan || opIfB.isNan ||
                   (opIfA.isInf && opIfB.isInf && (opIfA.sign != opIfB.sign));

  assign infA = {opIfA.sign, fpAddPkg::fpExp'(fpAddPkg::expMax), fpAddPkg::fpMan'(0)};
  assign infB = {opIfB.sign, fpAddPkg::fpExp'(fpAddPkg::expMax), fpAddPkg::fpMan'(0)};

  // Rebuilt from classified fields so the flush applies
  assign flushA = {opIfA.sign, opIfA.exp, opIfA.sig[fpAddPkg::manWidth-1:0]};
  assign flushB = {opIfB.sign, opIfB.exp, opIfB.sig[fpAddPkg::manWidth-1:0]};

  always_comb begin
    if (invalid) begin
      sum = fpAddPkg::quietNan;
    end else if (opIfA.isInf) begin
      sum = infA;
    end else if (opIfB.isInf) begin
      sum = infB;
    end else if (opIfA.isZero && opIfB.isZero) begin
      sum = {opIfA.sign & opIfB.sign, {(fpAddPkg::wordWidth-1){1'b0}}};  // -0 only if both
    end else if (opIfA.isZero) begin
      sum = flushB;
    end else if (opIfB.isZero) begin
      sum = flushA;
    end else begin
      sum = normResult;
    end
  end

endmodule

//--- source/fpAddNorm.sv
// Significand add/subtract, normalization, round to nearest even and packing
`timescale 1ns/1ps

module fpAddNorm (
  fpAlignIf.consumer      aligned,
  output fpAddPkg::fpWord result
);

  localparam int sumWidth = fpAddPkg::alignWidth + 1;  // Room for carry-out
  localparam int eWidth   = fpAddPkg::expWidth + 2;    // Signed, catches wrap

  logic [sumWidth-1:0]        rawSum;
  logic                       carryOut;
  logic [4:0]                 lzc;
  fpAddPkg::fpAlignSig        normSig;
  logic signed [eWidth-1:0]   baseExp;
  logic signed [eWidth-1:0]   normExp;
  logic signed [eWidth-1:0]   finalExp;
  fpAddPkg::fpSig             keepSig;
  logic                       guardBit;
  logic                       roundBit;
  logic                       stickyBit;
  logic                       roundUp;
  logic [fpAddPkg::sigWidth:0] roundedSig;
  fpAddPkg::fpSig             finalSig;

  // ==========================================================================
  // Add or subtract; ordering keeps the difference non-negative
  // ==========================================================================
  always_comb begin
    if (aligned.effSub) begin
      rawSum = {1'b0, aligned.bigSig} - {1'b0, aligned.smallSig};
    end else begin
      rawSum = {1'b0, aligned.bigSig} + {1'b0, aligned.smallSig};
    end
  end

  assign carryOut = rawSum[sumWidth-1];
  assign baseExp  = $signed({2'b00, aligned.bigExp});

  // Leading zero count of the low 27 bits, highest set bit wins
  always_comb begin
    lzc = '0;
    for (int i = 0; i < fpAddPkg::alignWidth; i++) begin
      if (rawSum[i]) begin
        lzc = 5'(fpAddPkg::alignWidth - 1 - i);
      end
    end
  end

  // ==========================================================================
  // Normalize
  // ==========================================================================
  always_comb begin
    if (carryOut) begin
      // One step right, shifted-out bit folds into sticky
      normSig = {rawSum[sumWidth-1:2], rawSum[1] | rawSum[0]};
      normExp = baseExp + 1;
    end else begin
      normSig = rawSum[fpAddPkg::alignWidth-1:0] << lzc;
      normExp = baseExp - $signed({{(eWidth-5){1'b0}}, lzc});
    end
  end

  // ==========================================================================
  // Round to nearest, ties to even
  // ==========================================================================
  assign keepSig   = normSig[fpAddPkg::alignWidth-1:3];
  assign guardBit  = normSig[2];
  assign roundBit  = normSig[1];
  assign stickyBit = normSig[0];
  assign roundUp   = guardBit & (roundBit | stickyBit | keepSig[0]);

  assign roundedSig = {1'b0, keepSig} + (fpAddPkg::sigWidth + 1)'(roundUp);

  always_comb begin
    if (roundedSig[fpAddPkg::sigWidth]) begin  // Rounding carried past hidden bit
      finalSig = roundedSig[fpAddPkg::sigWidth:1];
      finalExp = normExp + 1;
    end else begin
      finalSig = roundedSig[fpAddPkg::sigWidth-1:0];
      finalExp = normExp;
    end
  end

  // Pack with overflow and underflow clamps
  always_comb begin
    if (rawSum == '0) begin
      result = '0;  // Exact cancellation is +0
    end else if (finalExp >= fpAddPkg::expMax) begin
      result = {aligned.bigSign, fpAddPkg::fpExp'(fpAddPkg::expMax), fpAddPkg::fpMan'(0)};
    end else if (finalExp <= 0) begin
      result = {aligned.bigSign, {(fpAddPkg::wordWidth-1){1'b0}}};
    end else begin
      result = {aligned.bigSign, finalExp[fpAddPkg::expWidth-1:0],
                finalSig[fpAddPkg::manWidth-1:0]};
    end
  end

endmodule

//--- source/fpAlign.sv
// Magnitude ordering and right-shift alignment with sticky collection
`timescale 1ns/1ps

module fpAlign (
  fpOperandIf.consumer a,
  fpOperandIf.consumer b,
  fpAlignIf.producer   aligned
);

  localparam int maxShift = fpAddPkg::alignWidth - 1;  // 26

  logic                aIsBig;
  fpAddPkg::fpExp      smallExp;
  fpAddPkg::fpSig      smallRaw;
  fpAddPkg::fpExp      expDiff;
  fpAddPkg::fpAlignSig smallExt;
  fpAddPkg::fpAlignSig shifted;
  fpAddPkg::fpAlignSig lostMask;
  logic                sticky;

  // Exponent first, significand breaks the tie
  assign aIsBig = (a.exp > b.exp) || ((a.exp == b.exp) && (a.sig >= b.sig));

  assign aligned.bigSign = aIsBig ? a.sign : b.sign;
  assign aligned.bigExp  = aIsBig ? a.exp : b.exp;
  assign aligned.bigSig  = aIsBig ? {a.sig, 3'b000} : {b.sig, 3'b000};
  assign aligned.effSub  = a.sign ^ b.sign;

  assign smallExp = aIsBig ? b.exp : a.exp;
  assign smallRaw = aIsBig ? b.sig : a.sig;
  assign expDiff  = aligned.bigExp - smallExp;  // Never negative
  assign smallExt = {smallRaw, 3'b000};

  // ==========================================================================
  // Right shift with sticky
  // ==========================================================================
  always_comb begin
    if (expDiff > fpAddPkg::fpExp'(maxShift)) begin
      // Everything falls off the end
      shifted  = '0;
      lostMask = '1;
    end else begin
      shifted  = smallExt >> expDiff;
      lostMask = ~({fpAddPkg::alignWidth{1'b1}} << expDiff);
    end
    sticky = |(smallExt & lostMask);
  end

  assign aligned.smallSig = {shifted[fpAddPkg::alignWidth-1:1], shifted[0] | sticky};

endmodule

//--- source/fpClassify.sv
// Operand field split with zero, infinity and NaN flags and subnormal flush
`timescale 1ns/1ps

module fpClassify (
  input  fpAddPkg::fpWord operand,
  fpOperandIf.producer    op
);

  fpAddPkg::fpExp expField;
  fpAddPkg::fpMan manField;
  logic           expZero;
  logic           expOnes;

  // Field extraction
  assign expField = operand[fpAddPkg::wordWidth-2 -: fpAddPkg::expWidth];
  assign manField = operand[fpAddPkg::manWidth-1:0];

  assign expZero = (expField == '0);
  assign expOnes = (expField == fpAddPkg::fpExp'(fpAddPkg::expMax));

  assign op.sign = operand[fpAddPkg::wordWidth-1];
  assign op.exp  = expField;

  // Zero exponent covers true zero and subnormals, both treated as zero
  assign op.isZero = expZero;
  assign op.isInf  = expOnes && (manField == '0);
  assign op.isNan  = expOnes && (manField != '0);

  // Hidden bit only for nonzero operands; fraction dropped on flush
  always_comb begin
    if (expZero) begin
      op.sig = '0;
    end else begin
      op.sig = {1'b1, manField};
    end
  end

endmodule

//--- source/fpAlignIf.sv
// Interface for the magnitude-ordered, exponent-aligned operand pair
`timescale 1ns/1ps

interface fpAlignIf;

  logic                bigSign;
  fpAddPkg::fpExp      bigExp;
  fpAddPkg::fpAlignSig bigSig;
  fpAddPkg::fpAlignSig smallSig;  // Shifted with sticky in bit 0
  logic                effSub;    // Operand signs differ

  modport producer (
    output bigSign, bigExp, bigSig, smallSig, effSub
  );

  modport consumer (
    input bigSign, bigExp, bigSig, smallSig, effSub
  );

endinterface

//--- source/fpOperandIf.sv
// Interface for one classified binary32 operand
`timescale 1ns/1ps

interface fpOperandIf;

  logic             sign;
  fpAddPkg::fpExp   exp;
  fpAddPkg::fpSig   sig;     // Hidden bit set unless zero
  logic             isZero;  // Includes flushed subnormals
  logic             isInf;
  logic             isNan;

  modport producer (
    output sign, exp, sig, isZero, isInf, isNan
  );

  modport consumer (
    input sign, exp, sig, isZero, isInf, isNan
  );

endinterface

//--- source/fpAddPkg.sv
// Binary32 format widths, datapath vector types and the handshake state enum
package fpAddPkg;

  // ==========================================================================
  // Format widths
  // ==========================================================================
  localparam int wordWidth  = 32;
  localparam int expWidth   = 8;
  localparam int manWidth   = 23;
  localparam int sigWidth   = manWidth + 1;  // Hidden bit on top
  localparam int alignWidth = sigWidth + 3;  // Guard, round, sticky
  localparam int expMax     = 255;           // All-ones exponent

  // ==========================================================================
  // Vector types
  // ==========================================================================
  typedef logic [wordWidth-1:0]  fpWord;
  typedef logic [expWidth-1:0]   fpExp;
  typedef logic [manWidth-1:0]   fpMan;
  typedef logic [sigWidth-1:0]   fpSig;
  typedef logic [alignWidth-1:0] fpAlignSig;

  // Canonical quiet NaN for every invalid result
  localparam fpWord quietNan = 32'h7FC00000;

  // ==========================================================================
  // Handshake unit states
  // ==========================================================================
  typedef enum logic [1:0] {
    stateIdle,     // Waiting for req
    stateCompute,  // Operands latched, datapath settling
    stateHold,     // Result registered, ack high until req drops
    stateRelease   // Return-to-zero phase
  } unitState;

endpackage
